// ==== hw/decomp_pkg.sv ====
package decomp_pkg;

    // one compress group is also one memory word
    localparam int GROUP_BITS   = 64;
    localparam int UNIT_COUNT   = 5;   // zero-run-length units per group
    localparam int ZERO_BITS    = 4;   // zero run field at the bottom of a unit
    localparam int VAL_BITS     = 8;   // value field above the zero run
    localparam int UNIT_BITS    = ZERO_BITS + VAL_BITS;
    localparam int END_LSB      = UNIT_COUNT * UNIT_BITS; // end code sits right above unit 4
    localparam int END_BITS     = 3;
    localparam int FLAG_BIT     = GROUP_BITS - 1;        // set when the end unit keeps its value

    // the global buffer takes eight bytes per packet
    localparam int PACKET_BYTES = 8;

    typedef logic [GROUP_BITS-1:0]            group_t;
    typedef logic [PACKET_BYTES*VAL_BITS-1:0] packet_data_t;
    typedef logic [PACKET_BYTES-1:0]          packet_mask_t;

    // names the unit where the stream stops, or says the group is not the end
    typedef enum logic [END_BITS-1:0] {
        END_UNIT0 = 3'd0,
        END_UNIT1 = 3'd1,
        END_UNIT2 = 3'd2,
        END_UNIT3 = 3'd3,
        END_UNIT4 = 3'd4,
        END_NONE  = 3'd7
    } end_code_e;

    typedef enum logic [1:0] {
        RUN_IDLE,   // waiting for start
        RUN_FETCH,  // reading groups until the end group comes back
        RUN_DRAIN   // end group seen, waiting for the last packet to leave
    } run_state_e;

    typedef enum logic [1:0] {
        EXP_LOAD,   // copy the head group out of the buffer
        EXP_ZEROS,  // emit the zeros of the current unit
        EXP_VALUE   // emit the value of the current unit
    } exp_state_e;

endpackage

// ==== hw/decomp_ctrl.sv ====
`timescale 1ns/1ps

module decomp_ctrl #(
    parameter int unsigned DATA_FIFO_DEPTH = 16
) (
    input  logic                  layer23_gated_clk,
    input  logic                  rst_n,
    input  logic                  start,          // one-cycle pulse that opens a run
    input  logic                  mem_ack,
    input  logic                  mem_data_valid,
    input  decomp_pkg::end_code_e mem_end_code,   // end code field of the returning word
    input  logic                  group_pop,      // expander consumed the head group
    input  logic                  run_done,       // last packet has been taken
    output logic                  mem_req,
    output logic                  fifo_write,
    output logic                  busy
);
    import decomp_pkg::*;

    // one extra bit so the counter can reach DATA_FIFO_DEPTH itself
    localparam int CNT_W = $clog2(DATA_FIFO_DEPTH) + 1;

    run_state_e       state;
    logic [CNT_W-1:0] credits;      // reads in flight plus groups sitting in the buffer
    logic [CNT_W-1:0] credits_next;
    logic             issue;        // a read leaves for memory this cycle
    logic             dropped;      // returning data that the buffer will never see
    logic             end_seen;     // the word being written closes the stream

    // credits keep the buffer from overflowing, so no full flag is needed downstream
    assign mem_req    = (state == RUN_FETCH) && (credits < CNT_W'(DATA_FIFO_DEPTH));
    assign issue      = mem_req && mem_ack;
    assign fifo_write = mem_data_valid && (state == RUN_FETCH); // writes stop after the end group
    assign dropped    = mem_data_valid && (state != RUN_FETCH);
    assign end_seen   = fifo_write && (mem_end_code != END_NONE);
    assign busy       = (state != RUN_IDLE);

    // a pop and a dropped word can land in the same cycle and each frees one credit
    assign credits_next = credits + CNT_W'(issue) - CNT_W'(group_pop) - CNT_W'(dropped);

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= RUN_IDLE;
            credits <= '0;
        end else if (start) begin
            state   <= RUN_FETCH;   // mem_req comes up on the following cycle
            credits <= '0;
        end else begin
            credits <= credits_next;
            if (run_done) begin
                state <= RUN_IDLE;
            end else if (state == RUN_FETCH && end_seen) begin
                state <= RUN_DRAIN; // mem_req falls on this same edge
            end
        end
    end

endmodule

// ==== hw/group_fifo.sv ====
`timescale 1ns/1ps

module group_fifo #(
    parameter int unsigned DATA_FIFO_DEPTH = 16
) (
    input  logic               layer23_gated_clk,
    input  logic               rst_n,
    input  logic               start,        // clears both pointers for a new run
    input  logic               fifo_write,
    input  decomp_pkg::group_t mem_data,
    input  logic               group_pop,
    output decomp_pkg::group_t head_group,
    output logic               fifo_empty
);
    import decomp_pkg::*;

    localparam int AW = $clog2(DATA_FIFO_DEPTH);

    group_t        mem [DATA_FIFO_DEPTH];
    logic [AW:0]   wr_ptr;   // top bit flips on every wrap
    logic [AW:0]   rd_ptr;
    logic          do_pop;

    // the controller never lets more than DATA_FIFO_DEPTH groups be in flight
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign head_group = mem[rd_ptr[AW-1:0]];   // head is visible the cycle after its write
    assign do_pop     = group_pop && !fifo_empty;

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (start) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fifo_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // each entry holds one group, written at the write pointer
    always_ff @(posedge layer23_gated_clk) begin
        if (fifo_write) begin
            mem[wr_ptr[AW-1:0]] <= mem_data;
        end
    end

endmodule

// ==== hw/unit_expander.sv ====
`timescale 1ns/1ps

module unit_expander (
    input  logic                            layer23_gated_clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  decomp_pkg::group_t              head_group,
    input  logic                            fifo_empty,
    input  logic                            byte_ready,    // packer can take a byte this cycle
    output logic                            group_pop,
    output logic                            byte_valid,
    output logic [decomp_pkg::VAL_BITS-1:0] byte_data,
    output logic                            byte_last      // final byte of the whole run
);
    import decomp_pkg::*;

    exp_state_e           state;
    group_t               grp;          // local copy of the group being expanded
    logic [2:0]           unit_idx;     // unit under work, 0 to UNIT_COUNT-1
    logic [2:0]           nxt_idx;
    logic [ZERO_BITS-1:0] zero_cnt;     // zeros still to emit for this unit
    logic                 cur_end;      // current unit is where the stream stops
    logic                 cur_val;      // current unit contributes its value
    logic                 next_empty;   // the next unit is the end unit and gives nothing

    function automatic logic [ZERO_BITS-1:0] unit_zero(input group_t g, input logic [2:0] idx);
        return g[UNIT_BITS*idx +: ZERO_BITS];
    endfunction

    function automatic logic [VAL_BITS-1:0] unit_val(input group_t g, input logic [2:0] idx);
        return g[UNIT_BITS*idx + ZERO_BITS +: VAL_BITS];
    endfunction

    function automatic logic is_end_unit(input group_t g, input logic [2:0] idx);
        end_code_e code;
        code = end_code_e'(g[END_LSB +: END_BITS]);
        return (code != END_NONE) && (g[END_LSB +: END_BITS] == idx);
    endfunction

    // the end unit keeps its value only when the end flag is set
    function automatic logic gives_val(input group_t g, input logic [2:0] idx);
        return !is_end_unit(g, idx) || g[FLAG_BIT];
    endfunction

    // state to enter when the walk arrives at a unit
    function automatic exp_state_e enter_state(input group_t g, input logic [2:0] idx);
        if (unit_zero(g, idx) != '0) begin
            return EXP_ZEROS;
        end else if (gives_val(g, idx) || idx == 3'd0) begin
            return EXP_VALUE;   // unit 0 with nothing still needs the bare last pulse
        end
        return EXP_LOAD;        // end unit with nothing, last byte was already marked
    endfunction

    assign nxt_idx    = unit_idx + 3'd1;
    assign cur_end    = is_end_unit(grp, unit_idx);
    assign cur_val    = gives_val(grp, unit_idx);
    assign next_empty = is_end_unit(grp, nxt_idx) && (unit_zero(grp, nxt_idx) == '0)
                        && !grp[FLAG_BIT];

    assign group_pop  = (state == EXP_LOAD) && !fifo_empty; // copy and pop on the same edge
    assign byte_valid = (state == EXP_ZEROS) || (state == EXP_VALUE && cur_val);
    assign byte_data  = (state == EXP_VALUE) ? unit_val(grp, unit_idx) : '0;

    // look ahead inside the copied group so the last emitted byte carries the mark
    always_comb begin
        byte_last = 1'b0;
        if (state == EXP_ZEROS) begin
            byte_last = (zero_cnt == ZERO_BITS'(1)) && cur_end && !grp[FLAG_BIT];
        end else if (state == EXP_VALUE) begin
            byte_last = cur_end || next_empty; // empty stream gives this with byte_valid low
        end
    end

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= EXP_LOAD;
            unit_idx <= '0;
            zero_cnt <= '0;
        end else if (start) begin
            state    <= EXP_LOAD;
            unit_idx <= '0;
            zero_cnt <= '0;
        end else begin
            case (state)
                EXP_LOAD: if (!fifo_empty) begin
                    state    <= enter_state(head_group, 3'd0);
                    unit_idx <= '0;
                    zero_cnt <= unit_zero(head_group, 3'd0);
                end
                EXP_ZEROS: if (byte_ready) begin
                    zero_cnt <= zero_cnt - 1'b1;
                    if (zero_cnt == ZERO_BITS'(1)) begin
                        state <= cur_val ? EXP_VALUE : EXP_LOAD;
                    end
                end
                EXP_VALUE: if (byte_ready) begin
                    if (cur_end || unit_idx == 3'(UNIT_COUNT - 1)) begin
                        state <= EXP_LOAD;  // group finished, fetch the next head
                    end else begin
                        state    <= enter_state(grp, nxt_idx);
                        unit_idx <= nxt_idx;
                        zero_cnt <= unit_zero(grp, nxt_idx);
                    end
                end
                default: state <= EXP_LOAD;
            endcase
        end
    end

    always_ff @(posedge layer23_gated_clk) begin
        if (group_pop) begin
            grp <= head_group;
        end
    end

endmodule

// ==== hw/packet_packer.sv ====
`timescale 1ns/1ps

module packet_packer (
    input  logic                            layer23_gated_clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic                            byte_valid,
    input  logic [decomp_pkg::VAL_BITS-1:0] byte_data,
    input  logic                            byte_last,
    input  logic                            ifmap_buffer_req,
    output logic                            byte_ready,
    output decomp_pkg::packet_data_t        packet_data,
    output decomp_pkg::packet_mask_t        packet_mask,
    output logic                            decompressor_ack,
    output logic                            run_done
);
    import decomp_pkg::*;

    localparam int SLOT_W = $clog2(PACKET_BYTES);

    logic [SLOT_W-1:0] slot_ptr;    // next free slot in the packet
    logic              last_pkt;    // packet waiting now closes the run
    logic              handshake;
    logic              accept;      // expander handed over a byte or a bare last pulse
    logic              slot_full;   // this byte fills the final slot

    assign byte_ready = !decompressor_ack;   // nothing enters while a packet waits
    assign handshake  = decompressor_ack && ifmap_buffer_req;
    assign accept     = byte_ready && (byte_valid || byte_last);
    assign slot_full  = (slot_ptr == SLOT_W'(PACKET_BYTES - 1));

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_ptr         <= '0;
            packet_mask      <= '0;
            decompressor_ack <= 1'b0;
            last_pkt         <= 1'b0;
            run_done         <= 1'b0;
        end else if (start) begin
            slot_ptr         <= '0;
            packet_mask      <= '0;
            decompressor_ack <= 1'b0;
            last_pkt         <= 1'b0;
            run_done         <= 1'b0;
        end else begin
            run_done <= 1'b0;
            if (handshake) begin
                slot_ptr         <= '0;
                packet_mask      <= '0;
                decompressor_ack <= 1'b0;
                last_pkt         <= 1'b0;
                run_done         <= last_pkt;   // one pulse once the final packet is gone
            end else if (accept) begin
                if (byte_valid) begin
                    packet_mask[slot_ptr] <= 1'b1;
                    slot_ptr              <= slot_ptr + 1'b1;
                end
                if (byte_last) begin
                    // a bare last pulse on an empty packet ends the run with no packet
                    if (byte_valid || packet_mask != '0) begin
                        decompressor_ack <= 1'b1;
                        last_pkt         <= 1'b1;
                    end else begin
                        run_done <= 1'b1;
                    end
                end else if (byte_valid && slot_full) begin
                    decompressor_ack <= 1'b1;
                end
            end
        end
    end

    // byte lanes follow the mask, stale lanes are zeroed after each handshake
    always_ff @(posedge layer23_gated_clk) begin
        if (handshake) begin
            packet_data <= '0;
        end else if (accept && byte_valid) begin
            packet_data[slot_ptr*VAL_BITS +: VAL_BITS] <= byte_data;
        end
    end

endmodule

// ==== hw/decompressor_top.sv ====
`timescale 1ns/1ps

module decompressor_top #(
    parameter int unsigned DATA_FIFO_DEPTH = 16
) (
    input  logic                     layer23_gated_clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     mem_ack,
    input  decomp_pkg::group_t       mem_data,
    input  logic                     mem_data_valid,
    input  logic                     ifmap_buffer_req,
    output logic                     mem_req,
    output logic                     busy,
    output decomp_pkg::packet_data_t packet_data,
    output decomp_pkg::packet_mask_t packet_mask,
    output logic                     decompressor_ack
);
    import decomp_pkg::*;

    end_code_e           mem_end_code;   // end code of the word coming back from memory
    logic                fifo_write;
    logic                fifo_empty;
    group_t              head_group;
    logic                group_pop;
    logic                byte_valid;
    logic [VAL_BITS-1:0] byte_data;
    logic                byte_last;
    logic                byte_ready;
    logic                run_done;

    assign mem_end_code = end_code_e'(mem_data[END_LSB +: END_BITS]);

    // run state and read credits
    decomp_ctrl #(
        .DATA_FIFO_DEPTH (DATA_FIFO_DEPTH)
    ) u_ctrl (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_ack           (mem_ack),
        .mem_data_valid    (mem_data_valid),
        .mem_end_code      (mem_end_code),
        .group_pop         (group_pop),
        .run_done          (run_done),
        .mem_req           (mem_req),
        .fifo_write        (fifo_write),
        .busy              (busy)
    );

    group_fifo #(
        .DATA_FIFO_DEPTH (DATA_FIFO_DEPTH)
    ) u_fifo (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .fifo_write        (fifo_write),
        .mem_data          (mem_data),
        .group_pop         (group_pop),
        .head_group        (head_group),
        .fifo_empty        (fifo_empty)
    );

    // one byte per cycle out of the head group
    unit_expander u_expander (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .head_group        (head_group),
        .fifo_empty        (fifo_empty),
        .byte_ready        (byte_ready),
        .group_pop         (group_pop),
        .byte_valid        (byte_valid),
        .byte_data         (byte_data),
        .byte_last         (byte_last)
    );

    packet_packer u_packer (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .byte_valid        (byte_valid),
        .byte_data         (byte_data),
        .byte_last         (byte_last),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .byte_ready        (byte_ready),
        .packet_data       (packet_data),
        .packet_mask       (packet_mask),
        .decompressor_ack  (decompressor_ack),
        .run_done          (run_done)
    );

endmodule

// ==== testbench/decompressor_properties.sv ====
`timescale 1ns/1ps

module decompressor_properties (
    input logic                     layer23_gated_clk,
    input logic                     rst_n,
    input logic                     mem_req,
    input logic                     busy,
    input logic                     ifmap_buffer_req,
    input logic                     decompressor_ack,
    input decomp_pkg::packet_data_t packet_data,
    input decomp_pkg::packet_mask_t packet_mask
);
    import decomp_pkg::*;

    packet_data_t kept_data;            // lanes outside the mask read as zero
    packet_mask_t mask_plus1;           // ones from slot 0 carry out and leave no overlap
    logic         fail_seen = 1'b0;     // set by any property that fails

    always_comb begin
        for (int i = 0; i < PACKET_BYTES; i++) begin
            kept_data[VAL_BITS*i +: VAL_BITS] =
                packet_mask[i] ? packet_data[VAL_BITS*i +: VAL_BITS] : '0;
        end
    end

    assign mask_plus1 = packet_mask + 1'b1;

    reset_quiet: assert property (@(posedge layer23_gated_clk)
        !rst_n |-> !mem_req && !decompressor_ack && !busy)
        else begin $error("outputs not low during reset"); fail_seen = 1'b1; end

    // memory is only asked for data while a run is going on
    req_needs_busy: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        !busy |-> !mem_req)
        else begin $error("mem_req high while idle"); fail_seen = 1'b1; end

    mask_contiguous: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        decompressor_ack |-> packet_mask != '0 && (mask_plus1 & packet_mask) == '0)
        else begin $error("packet mask not filled from slot 0"); fail_seen = 1'b1; end

    hold_while_stalled: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        decompressor_ack && !ifmap_buffer_req |=>
            decompressor_ack && $stable(packet_mask) && $stable(kept_data))
        else begin $error("waiting packet changed before it was taken"); fail_seen = 1'b1; end

endmodule

bind decompressor_top decompressor_properties u_props (.*);

// ==== testbench/tb_decompressor.sv ====
`timescale 1ns/1ps

module tb_decompressor;
    import decomp_pkg::*;

    localparam int unsigned DATA_FIFO_DEPTH = 16;
    localparam int unsigned WAIT_LIMIT      = 50000;   // cycles allowed for any single wait

    logic         layer23_gated_clk;
    logic         rst_n;
    logic         start;
    logic         mem_ack          = 1'b0;
    group_t       mem_data         = '0;
    logic         mem_data_valid   = 1'b0;
    logic         ifmap_buffer_req = 1'b0;
    logic         mem_req;
    logic         busy;
    packet_data_t packet_data;
    packet_mask_t packet_mask;
    logic         decompressor_ack;

    group_t              stream_q[$];      // groups of the current stream, end group last
    logic [VAL_BITS-1:0] exp_q[$];         // bytes still expected from the DUT
    group_t              resp_data[$];     // reads in flight, oldest first
    int unsigned         resp_due[$];      // cycle on which each of those reads returns
    int unsigned         cycle_cnt    = 0;
    int unsigned         last_due     = 0;
    int unsigned         mem_idx      = 0; // next stream group that memory hands out
    int unsigned         stall_left   = 0;
    int unsigned         req_pct      = 50;
    int                  groups_held  = 0; // reads issued and not yet popped or dropped
    logic                end_returned = 1'b0;

    decompressor_top #(.DATA_FIFO_DEPTH(DATA_FIFO_DEPTH)) u_decompressor_top (.*);

    initial begin
        layer23_gated_clk = 1'b0;
        forever #10 layer23_gated_clk = ~layer23_gated_clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // random groups ending in one end group, and the bytes they expand to by the format rules
    task automatic build_stream(input int unsigned n_groups);
        group_t      g;
        int unsigned code;
        stream_q.delete();
        exp_q.delete();
        for (int unsigned k = 0; k < n_groups; k++) begin
            g = {$urandom, $urandom};
            for (int u = 0; u < UNIT_COUNT; u++) begin
                if ($urandom % 3 == 0) g[UNIT_BITS*u +: ZERO_BITS] = '0; // value with no zeros
            end
            code = (k == n_groups - 1) ? $urandom % UNIT_COUNT : 7;
            g[END_LSB +: END_BITS] = END_BITS'(code);
            stream_q.push_back(g);
            for (int unsigned u = 0; u < UNIT_COUNT; u++) begin
                if (code != 7 && u > code) break;   // units past the end give nothing
                repeat (g[UNIT_BITS*u +: ZERO_BITS]) exp_q.push_back('0);
                if (code == 7 || u != code || g[GROUP_BITS-1]) begin
                    exp_q.push_back(g[UNIT_BITS*u + ZERO_BITS +: VAL_BITS]);
                end
            end
        end
    endtask

    task automatic check_packet();
        int unsigned         n;
        logic [VAL_BITS-1:0] want;
        n = $countones(packet_mask);
        assert (exp_q.size() >= n) else stop_on_error($sformatf(
            "mismatch at %0t: packet carries %0d bytes, %0d expected", $time, n, exp_q.size()));
        for (int unsigned i = 0; i < n; i++) begin
            want = exp_q.pop_front();
            assert (packet_data[VAL_BITS*i +: VAL_BITS] == want) else stop_on_error($sformatf(
                "mismatch at %0t: slot %0d holds %02h, expected %02h", $time, i,
                packet_data[VAL_BITS*i +: VAL_BITS], want));
        end
        // only the packet that closes the stream may be partial
        assert (exp_q.size() == 0 || packet_mask == '1) else stop_on_error($sformatf(
            "mismatch at %0t: partial mask %02h before the stream end", $time, packet_mask));
    endtask

    // memory answers in issue order after 1 to 6 cycles and pads past the stream end
    always @(posedge layer23_gated_clk) begin
        group_t      word;
        int unsigned due;
        cycle_cnt = cycle_cnt + 1;
        if (end_returned) begin
            assert (!mem_req) else stop_on_error("memory was asked for data after the end group");
        end
        // a word returned past the end group never reaches the buffer and frees its slot
        if (mem_data_valid && end_returned) groups_held = groups_held - 1;
        if (u_decompressor_top.group_pop) groups_held = groups_held - 1;
        if (mem_data_valid && mem_data[END_LSB +: END_BITS] != END_NONE) end_returned = 1'b1;
        if (mem_req && mem_ack) begin
            word = {$urandom, $urandom};
            word[END_LSB +: END_BITS] = END_NONE;   // trailing words are never an end group
            if (mem_idx < stream_q.size()) word = stream_q[mem_idx];
            mem_idx = mem_idx + 1;
            due = cycle_cnt + 1 + $urandom % 6;
            if (due <= last_due) due = last_due + 1; // one word per cycle on the return bus
            last_due = due;
            resp_due.push_back(due);
            resp_data.push_back(word);
            groups_held = groups_held + 1;
            assert (groups_held <= int'(DATA_FIFO_DEPTH))
                else stop_on_error("more reads outstanding than the group buffer can hold");
        end
        mem_ack <= ($urandom % 4) != 0;
        if (resp_due.size() != 0 && resp_due[0] == cycle_cnt) begin
            mem_data_valid <= 1'b1;
            mem_data       <= resp_data.pop_front();
            void'(resp_due.pop_front());
        end else begin
            mem_data_valid <= 1'b0;
        end
    end

    // global buffer takes packets at random and now and then stalls for a long stretch
    always @(posedge layer23_gated_clk) begin
        if (decompressor_ack && ifmap_buffer_req) check_packet();
        if (stall_left != 0) begin
            stall_left = stall_left - 1;
            ifmap_buffer_req <= 1'b0;
        end else begin
            if ($urandom % 128 == 0) stall_left = 40 + $urandom % 60; // long enough to fill up
            ifmap_buffer_req <= ($urandom % 100) < req_pct;
        end
    end

    // stop as soon as a port property has fired
    always @(posedge layer23_gated_clk) begin
        assert (u_decompressor_top.u_props.fail_seen !== 1'b1)
            else stop_on_error("a property on the DUT ports failed");
    end

    task automatic run_stream(input int unsigned pct);
        int unsigned guard;
        build_stream(20 + $urandom % 20);
        req_pct      = pct;
        mem_idx      = 0;
        groups_held  = 0;
        end_returned = 1'b0;
        @(posedge layer23_gated_clk);
        start <= 1'b1;
        @(posedge layer23_gated_clk);
        start <= 1'b0;
        guard = 0;
        while (exp_q.size() != 0) begin
            @(posedge layer23_gated_clk);
            guard = guard + 1;
            assert (guard < WAIT_LIMIT) else stop_on_error("timeout waiting for the packets");
        end
        guard = 0;
        while (busy) begin
            @(posedge layer23_gated_clk);
            guard = guard + 1;
            assert (guard < WAIT_LIMIT) else stop_on_error("busy stayed high after the run");
        end
        guard = 0;
        while (resp_due.size() != 0 || mem_data_valid) begin   // trailing reads must drain
            @(posedge layer23_gated_clk);
            guard = guard + 1;
            assert (guard < WAIT_LIMIT) else stop_on_error("memory reads never drained");
        end
    endtask

    initial begin
        void'($urandom(32'heb7ed749));
        rst_n = 1'b0;
        start = 1'b0;
        repeat (16) @(posedge layer23_gated_clk);
        rst_n <= 1'b1;
        run_stream(60);   // mostly ready global buffer
        run_stream(25);   // heavy back-pressure on a fresh stream
        if (u_decompressor_top.u_props.fail_seen !== 1'b1) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_on_error("a property on the DUT ports failed");
        end
    end

endmodule

// ==== decompressor_top.f ====
hw/decomp_pkg.sv
hw/decomp_ctrl.sv
hw/group_fifo.sv
hw/unit_expander.sv
hw/packet_packer.sv
hw/decompressor_top.sv
testbench/decompressor_properties.sv
testbench/tb_decompressor.sv

// ==== Bender.yml ====
package:
  name: decompressor

sources:
  - files:
      - hw/decomp_pkg.sv
      - hw/decomp_ctrl.sv
      - hw/group_fifo.sv
      - hw/unit_expander.sv
      - hw/packet_packer.sv
      - hw/decompressor_top.sv
  - target: test
    files:
      - testbench/decompressor_properties.sv
      - testbench/tb_decompressor.sv
